/* data_memory.sv */
`default_nettype none

`include "rv_mem_params.svh"

module data_memory
    import rv_mem_pkg::*;
(
    input  wire             clk,
    input  wire             rst,

    input  wire             dreq_valid,
    input  wire             dreq_wen,
    input  wire word_t      dreq_addr,
    input  wire word_t      dreq_wdata,
    input  wire mem_size_t  dreq_size,
    output logic            dreq_ready,

    output logic            dresp_valid,
    output word_t           dresp_rdata
);

    localparam int CNT_W = $clog2(`DMEM_READ_LATENCY + 1);

    word_t mem [`DMEM_DEPTH] = '{default: '0};  // starts out cleared

    logic [15:0]      lfsr;
    logic [CNT_W-1:0] pend_cnt;   // cycles left until the load response
    dmem_addr_t       widx;
    logic [1:0]       boff;
    logic [3:0]       byte_en;
    word_t            wdata_sh;
    logic             accept;

    assign widx = dreq_addr[`DMEM_ADDR_BITS+1:2];
    assign boff = dreq_addr[1:0];

    // galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk) begin
        if (rst)
            lfsr <= `DMEM_READY_SEED;
        else
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
    end

    // one outstanding request, so ready stays low until the response is out
    assign dreq_ready = lfsr[0] && (pend_cnt == '0);
    assign accept     = dreq_valid && dreq_ready;

    always_comb begin
        case (dreq_size)
            SIZE_B:  byte_en = 4'b0001 << boff;
            SIZE_H:  byte_en = 4'b0011 << boff;
            default: byte_en = 4'b1111;
        endcase
        wdata_sh = dreq_wdata << {boff, 3'b000};  // move store data to its lane
    end

    always_ff @(posedge clk) begin
        if (accept && dreq_wen) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i])
                    mem[widx][8*i +: 8] <= wdata_sh[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            pend_cnt <= '0;
        else if (accept && !dreq_wen)
            pend_cnt <= CNT_W'(`DMEM_READ_LATENCY);
        else if (pend_cnt != '0)
            pend_cnt <= pend_cnt - 1'b1;
    end

    // read at acceptance, shifted down so the addressed byte lands in bits 7:0
    always_ff @(posedge clk) begin
        if (accept && !dreq_wen)
            dresp_rdata <= mem[widx] >> {boff, 3'b000};
    end

    // last count of the delay is the response cycle
    assign dresp_valid = (pend_cnt == CNT_W'(1));

endmodule

`default_nettype wire

/* mem_subsystem.f */
+incdir+.
rv_mem_pkg.sv
memory_stage.sv
data_memory.sv
mem_subsystem.sv
mem_subsystem_props.sv
mem_subsystem_tb.sv

/* mem_subsystem.sv */
`default_nettype none

module mem_subsystem
    import rv_mem_pkg::*;
(
    input  wire             clk,
    input  wire             rst,

    input  wire             mem_valid,
    input  wire word_t      mem_pc,
    input  wire inst_id_t   mem_inst_id,
    input  wire mem_op_t    mem_op,
    input  wire mem_size_t  mem_size,
    input  wire word_t      mem_alu_out,
    input  wire word_t      mem_rs2_data,

    input  wire             pipeline_flush,
    output logic            memory_unit_stall,

    output logic            mem_wb_valid,
    output word_t           mem_wb_pc,
    output inst_id_t        mem_wb_inst_id,
    output word_t           mem_wb_alu_out,
    output word_t           mem_wb_mem_rdata
);

    // stage to memory request and response
    logic       dreq_valid;
    logic       dreq_wen;
    word_t      dreq_addr;
    word_t      dreq_wdata;
    mem_size_t  dreq_size;
    logic       dreq_ready;
    logic       dresp_valid;
    word_t      dresp_rdata;

    memory_stage u_memory_stage (
        .clk               (clk),
        .rst               (rst),
        .mem_valid         (mem_valid),
        .mem_pc            (mem_pc),
        .mem_inst_id       (mem_inst_id),
        .mem_op            (mem_op),
        .mem_size          (mem_size),
        .mem_alu_out       (mem_alu_out),
        .mem_rs2_data      (mem_rs2_data),
        .pipeline_flush    (pipeline_flush),
        .memory_unit_stall (memory_unit_stall),
        .dreq_valid        (dreq_valid),
        .dreq_wen          (dreq_wen),
        .dreq_addr         (dreq_addr),
        .dreq_wdata        (dreq_wdata),
        .dreq_size         (dreq_size),
        .dreq_ready        (dreq_ready),
        .dresp_valid       (dresp_valid),
        .dresp_rdata       (dresp_rdata),
        .mem_wb_valid      (mem_wb_valid),
        .mem_wb_pc         (mem_wb_pc),
        .mem_wb_inst_id    (mem_wb_inst_id),
        .mem_wb_alu_out    (mem_wb_alu_out),
        .mem_wb_mem_rdata  (mem_wb_mem_rdata)
    );

    data_memory u_data_memory (
        .clk         (clk),
        .rst         (rst),
        .dreq_valid  (dreq_valid),
        .dreq_wen    (dreq_wen),
        .dreq_addr   (dreq_addr),
        .dreq_wdata  (dreq_wdata),
        .dreq_size   (dreq_size),
        .dreq_ready  (dreq_ready),
        .dresp_valid (dresp_valid),
        .dresp_rdata (dresp_rdata)
    );

endmodule

`default_nettype wire

/* mem_subsystem_props.sv */
`default_nettype none

`include "rv_mem_params.svh"

module mem_subsystem_props
    import rv_mem_pkg::*;
(
    input wire                clk,
    input wire                rst,
    input wire                pipeline_flush,
    input wire                memory_unit_stall,
    input wire                dreq_valid,
    input wire                dreq_wen,
    input wire word_t         dreq_addr,
    input wire word_t         dreq_wdata,
    input wire mem_size_t     dreq_size,
    input wire                dreq_ready,
    input wire                dresp_valid,
    input wire                mem_wb_valid,
    input wire stage_state_t  state
);
    timeunit 1ns;
    timeprecision 100ps;

    // request held until the memory takes it, unless flushed
    req_stable: assert property (@(posedge clk) disable iff (rst)
        (dreq_valid && !dreq_ready && !pipeline_flush)
            |=> (dreq_valid && $stable(dreq_addr) && $stable(dreq_wdata)
                 && $stable(dreq_wen) && $stable(dreq_size)))
        else $error("request changed while waiting for dreq_ready");

    // every response belongs to a load accepted a fixed time earlier
    resp_after_load: assert property (@(posedge clk) disable iff (rst)
        dresp_valid |-> $past(dreq_valid && dreq_ready && !dreq_wen, `DMEM_READ_LATENCY))
        else $error("dresp_valid without an accepted load");

    // stall gone and completion one cycle after the access ends
    wb_after_access: assert property (@(posedge clk) disable iff (rst)
        (((dreq_valid && dreq_ready && dreq_wen) || (state == ST_WAIT_RDATA && dresp_valid))
            && !pipeline_flush)
            |=> (!memory_unit_stall && (mem_wb_valid || pipeline_flush)))
        else $error("no completion in the cycle after the access ended");

    idle_after_reset: assert property (@(posedge clk)
        rst |=> (!memory_unit_stall && state == ST_IDLE))
        else $error("stage not idle after reset");

endmodule

bind memory_stage mem_subsystem_props u_props (
    .clk               (clk),
    .rst               (rst),
    .pipeline_flush    (pipeline_flush),
    .memory_unit_stall (memory_unit_stall),
    .dreq_valid        (dreq_valid),
    .dreq_wen          (dreq_wen),
    .dreq_addr         (dreq_addr),
    .dreq_wdata        (dreq_wdata),
    .dreq_size         (dreq_size),
    .dreq_ready        (dreq_ready),
    .dresp_valid       (dresp_valid),
    .mem_wb_valid      (mem_wb_valid),
    .state             (state)
);

`default_nettype wire

/* mem_subsystem_tb.sv */
`default_nettype none

module mem_subsystem_tb
    import rv_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_INSTR   = 400;
    localparam int MODEL_BYTES = 256;   // low 64 words
    localparam int MAX_CYCLES  = 200;   // per instruction

    logic       clk = 1'b0;
    logic       rst;
    logic       mem_valid;
    word_t      mem_pc;
    inst_id_t   mem_inst_id;
    mem_op_t    mem_op;
    mem_size_t  mem_size;
    word_t      mem_alu_out;
    word_t      mem_rs2_data;
    logic       pipeline_flush;
    logic       memory_unit_stall;
    logic       mem_wb_valid;
    word_t      mem_wb_pc;
    inst_id_t   mem_wb_inst_id;
    word_t      mem_wb_alu_out;
    word_t      mem_wb_mem_rdata;

    integer     seed = 32'h41e4;
    logic [7:0] model_mem [MODEL_BYTES];  // byte view of the RAM
    inst_id_t   next_id;
    int         n_done;
    int         n_flush;
    bit         run_passed = 1'b0;
    bit         fail_printed = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mem_subsystem DUT (
        .clk               (clk),
        .rst               (rst),
        .mem_valid         (mem_valid),
        .mem_pc            (mem_pc),
        .mem_inst_id       (mem_inst_id),
        .mem_op            (mem_op),
        .mem_size          (mem_size),
        .mem_alu_out       (mem_alu_out),
        .mem_rs2_data      (mem_rs2_data),
        .pipeline_flush    (pipeline_flush),
        .memory_unit_stall (memory_unit_stall),
        .mem_wb_valid      (mem_wb_valid),
        .mem_wb_pc         (mem_wb_pc),
        .mem_wb_inst_id    (mem_wb_inst_id),
        .mem_wb_alu_out    (mem_wb_alu_out),
        .mem_wb_mem_rdata  (mem_wb_mem_rdata)
    );

    task automatic report_failure(input string what);
        fail_printed = 1'b1;
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_eq(input string name, input word_t exp, input word_t act);
        assert (exp === act)
        else report_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_true(input string what, input bit cond);
        assert (cond)
        else report_failure(what);
    endtask

    // little endian byte writes, only the lanes of the access size
    function automatic void store_bytes(mem_size_t size, word_t addr, word_t data);
        int base;
        base = int'(addr[7:0]);
        model_mem[base] = data[7:0];
        if (size != SIZE_B)
            model_mem[base + 1] = data[15:8];
        if (size == SIZE_W) begin
            model_mem[base + 2] = data[23:16];
            model_mem[base + 3] = data[31:24];
        end
    endfunction

    // expected load result, extended by op and size
    function automatic word_t predict_load(mem_op_t op, mem_size_t size, word_t addr);
        int         base;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        word_t      val;
        base = int'(addr[7:0]);
        b0 = model_mem[base];
        b1 = 8'h00;
        b2 = 8'h00;
        b3 = 8'h00;
        if (size != SIZE_B)
            b1 = model_mem[base + 1];
        if (size == SIZE_W) begin
            b2 = model_mem[base + 2];
            b3 = model_mem[base + 3];
        end
        case (size)
            SIZE_B:  val = (op == MEM_LOAD_S) ? {{24{b0[7]}}, b0} : {24'h0, b0};
            SIZE_H:  val = (op == MEM_LOAD_S) ? {{16{b1[7]}}, b1, b0} : {16'h0, b1, b0};
            default: val = {b3, b2, b1, b0};
        endcase
        return val;
    endfunction

    task automatic idle_cycle();
        mem_valid = 1'b0;
        @(negedge clk);
        check_true("completion with no instruction present", !mem_wb_valid);
        check_true("stall high with no instruction present", !memory_unit_stall);
        @(posedge clk);
        #2;
    endtask

    // one random instruction, held until it completes or is flushed
    task automatic run_instr(input int n);
        int        rnd;
        int        rnd2;
        int        flush_cyc;
        int        cyc;
        bit        done;
        bit        xfer_seen;
        mem_op_t   op;
        mem_size_t size;
        word_t     addr;
        word_t     data;
        word_t     exp_rdata;
        string     tag;
        rnd  = $random(seed);
        rnd2 = $random(seed);
        op   = mem_op_t'(rnd[1:0]);
        size = mem_size_t'((rnd[3:2] == 2'd3) ? 2'd2 : rnd[3:2]);
        addr = {24'h0, rnd[9:4], 2'b00};  // naturally aligned
        if (size == SIZE_H)
            addr[1] = rnd[10];
        else if (size == SIZE_B)
            addr[1:0] = rnd[11:10];
        data      = $random(seed);
        flush_cyc = (rnd2[3:0] == 4'd0) ? int'(rnd2[6:4]) : -1;  // about 1 in 16
        tag       = $sformatf("instr %0d %s", n, op.name());

        mem_valid    = 1'b1;
        mem_pc       = {rnd2[31:2], 2'b00};
        mem_inst_id  = next_id;
        mem_op       = op;
        mem_size     = size;
        mem_alu_out  = (op == MEM_NONE) ? word_t'($random(seed)) : addr;
        mem_rs2_data = data;
        next_id      = next_id + 8'd1;

        cyc       = 0;
        done      = 1'b0;
        xfer_seen = 1'b0;
        while (!done) begin
            pipeline_flush = (cyc == flush_cyc);
            @(negedge clk);
            // the transfer lands at the coming edge, flushed or not
            if (DUT.dreq_valid && DUT.dreq_ready) begin
                check_true({tag, ": second transfer for one instruction"}, !xfer_seen);
                check_eq({tag, " dreq_addr"}, addr, DUT.dreq_addr);
                xfer_seen = 1'b1;
                if (op == MEM_STORE)
                    store_bytes(size, addr, data);
            end
            if (pipeline_flush) begin
                check_true({tag, ": completion during flush"}, !mem_wb_valid);
                n_flush++;
                done = 1'b1;
            end else if (mem_wb_valid) begin
                exp_rdata = (op == MEM_LOAD_S || op == MEM_LOAD_U) ?
                            predict_load(op, size, addr) : '0;
                check_eq({tag, " pc"}, mem_pc, mem_wb_pc);
                check_eq({tag, " inst_id"}, word_t'(mem_inst_id), word_t'(mem_wb_inst_id));
                check_eq({tag, " alu_out"}, mem_alu_out, mem_wb_alu_out);
                check_eq({tag, " rdata"}, exp_rdata, mem_wb_mem_rdata);
                check_true({tag, ": completion while stalled"}, !memory_unit_stall);
                if (op != MEM_NONE)
                    check_true({tag, ": completed without a transfer"}, xfer_seen);
                n_done++;
                done = 1'b1;
            end else begin
                check_true({tag, ": no completion but stall low"}, memory_unit_stall);
                check_true({tag, ": non-memory op stalled"}, op != MEM_NONE);
                check_true({tag, ": no completion in time"}, cyc < MAX_CYCLES);
            end
            @(posedge clk);
            #2;
            cyc++;
        end
        pipeline_flush = 1'b0;
    endtask

    initial begin
        rst            = 1'b1;
        mem_valid      = 1'b0;
        mem_pc         = '0;
        mem_inst_id    = '0;
        mem_op         = MEM_NONE;
        mem_size       = SIZE_W;
        mem_alu_out    = '0;
        mem_rs2_data   = '0;
        pipeline_flush = 1'b0;
        next_id        = 8'h00;
        n_done         = 0;
        n_flush        = 0;
        for (int i = 0; i < MODEL_BYTES; i++)
            model_mem[i] = 8'h00;  // RAM starts out cleared

        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;

        for (int n = 0; n < NUM_INSTR; n++) begin
            run_instr(n);
            if (($random(seed) & 7) == 0)
                idle_cycle();  // bubble now and then
        end
        idle_cycle();

        $display("%0d instructions, %0d completed, %0d flushed", NUM_INSTR, n_done, n_flush);
        run_passed = 1'b1;
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // watchdog, far beyond the worst ready wait per instruction
    initial begin
        #(NUM_INSTR * 40 * CLK_PERIOD);
        report_failure("timeout: the run did not finish in time");
    end

    final begin
        if (!run_passed && !fail_printed)
            $display("CHECKS FAILED");
    end

endmodule

`default_nettype wire

/* memory_stage.sv */
`default_nettype none

module memory_stage
    import rv_mem_pkg::*;
(
    input  wire             clk,
    input  wire             rst,

    input  wire             mem_valid,
    input  wire word_t      mem_pc,
    input  wire inst_id_t   mem_inst_id,
    input  wire mem_op_t    mem_op,
    input  wire mem_size_t  mem_size,
    input  wire word_t      mem_alu_out,
    input  wire word_t      mem_rs2_data,

    input  wire             pipeline_flush,
    output logic            memory_unit_stall,

    output logic            dreq_valid,
    output logic            dreq_wen,
    output word_t           dreq_addr,
    output word_t           dreq_wdata,
    output mem_size_t       dreq_size,
    input  wire             dreq_ready,

    input  wire             dresp_valid,
    input  wire word_t      dresp_rdata,

    output logic            mem_wb_valid,
    output word_t           mem_wb_pc,
    output inst_id_t        mem_wb_inst_id,
    output word_t           mem_wb_alu_out,
    output word_t           mem_wb_mem_rdata
);

    stage_state_t state;
    logic         cmd_done;     // access of saved_id already finished
    inst_id_t     saved_id;

    // request copy taken when the access starts
    mem_op_t      cur_op;
    mem_size_t    cur_size;
    word_t        req_addr;
    word_t        req_wdata;

    word_t        rdata_q;      // raw load data, already lane aligned

    logic         is_mem;
    logic         fresh;
    logic         issue;
    logic         is_load_op;

    // sign or zero extension of a loaded value
    function automatic word_t extend_load(
        input mem_op_t   op,
        input mem_size_t size,
        input word_t     raw
    );
        word_t res;
        case (size)
            SIZE_B: begin
                if (op == MEM_LOAD_S)
                    res = {{24{raw[7]}}, raw[7:0]};   // lb
                else
                    res = {24'b0, raw[7:0]};          // lbu
            end
            SIZE_H: begin
                if (op == MEM_LOAD_S)
                    res = {{16{raw[15]}}, raw[15:0]}; // lh
                else
                    res = {16'b0, raw[15:0]};         // lhu
            end
            default: res = raw;                       // lw
        endcase
        return res;
    endfunction

    assign is_mem = mem_valid && (mem_op != MEM_NONE);

    // a held instruction whose access is done must not go out again
    assign fresh = !(cmd_done && (saved_id == mem_inst_id));
    assign issue = (state == ST_IDLE) && is_mem && fresh;

    assign memory_unit_stall = (state != ST_IDLE) || issue;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            cmd_done <= 1'b0;
        end else if (pipeline_flush || !mem_valid) begin
            state    <= ST_IDLE;  // drop whatever was in flight
            cmd_done <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (issue) begin
                        state    <= ST_WAIT_READY;
                        cmd_done <= 1'b0;
                    end
                end
                ST_WAIT_READY: begin
                    if (dreq_ready) begin
                        if (cur_op == MEM_STORE) begin
                            state    <= ST_IDLE;
                            cmd_done <= 1'b1;  // store needs no response
                        end else begin
                            state <= ST_WAIT_RDATA;
                        end
                    end
                end
                ST_WAIT_RDATA: begin
                    if (dresp_valid) begin
                        state    <= ST_IDLE;
                        cmd_done <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // latch the request at issue so it stays put until the transfer
    always_ff @(posedge clk) begin
        if (issue) begin
            saved_id  <= mem_inst_id;
            cur_op    <= mem_op;
            cur_size  <= mem_size;
            req_addr  <= mem_alu_out;
            req_wdata <= mem_rs2_data;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT_RDATA && dresp_valid)
            rdata_q <= dresp_rdata;
    end

    assign dreq_valid = (state == ST_WAIT_READY);
    assign dreq_wen   = (cur_op == MEM_STORE);
    assign dreq_addr  = req_addr;
    assign dreq_wdata = req_wdata;  // low bytes, memory moves it to its lane
    assign dreq_size  = cur_size;

    assign is_load_op = (mem_op == MEM_LOAD_S) || (mem_op == MEM_LOAD_U);

    // completion: instruction present, nothing pending, not flushed
    assign mem_wb_valid     = mem_valid && !memory_unit_stall && !pipeline_flush;
    assign mem_wb_pc        = mem_pc;
    assign mem_wb_inst_id   = mem_inst_id;
    assign mem_wb_alu_out   = mem_alu_out;
    assign mem_wb_mem_rdata = is_load_op ? extend_load(mem_op, mem_size, rdata_q) : '0;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f mem_subsystem.f \
    --top-module mem_subsystem_tb -o mem_subsystem_sim \
    && ./obj_dir/mem_subsystem_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^ALL CHECKS PASSED$" sim.log && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }

/* rv_mem_params.svh */
`ifndef RV_MEM_PARAMS_SVH
`define RV_MEM_PARAMS_SVH

// data memory geometry
`define DMEM_DEPTH 256      // words
`define DMEM_ADDR_BITS 8    // word index bits, log2 of depth

// cycles from an accepted load to its response pulse
`define DMEM_READ_LATENCY 2

// start value of the ready pattern LFSR, must be nonzero
`define DMEM_READY_SEED 16'hace1

`endif

/* rv_mem_pkg.sv */
`default_nettype none

`include "rv_mem_params.svh"

package rv_mem_pkg;

    typedef logic [31:0] word_t;                      // data or byte address
    typedef logic [7:0]  inst_id_t;                   // instruction tag
    typedef logic [`DMEM_ADDR_BITS-1:0] dmem_addr_t;  // word index into the RAM

    // memory operation of the instruction in the stage
    typedef enum logic [1:0] {
        MEM_NONE   = 2'd0,
        MEM_STORE  = 2'd1,
        MEM_LOAD_S = 2'd2,  // lb, lh, lw
        MEM_LOAD_U = 2'd3   // lbu, lhu
    } mem_op_t;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_t;

    // memory stage FSM
    typedef enum logic [1:0] {
        ST_IDLE       = 2'd0,
        ST_WAIT_READY = 2'd1,  // request out, waiting for dreq_ready
        ST_WAIT_RDATA = 2'd2   // load accepted, waiting for dresp_valid
    } stage_state_t;

endpackage

`default_nettype wire
